// ==== design/atom_cassette.sv ====
// =========================================================================
// Cassette tone divider
// Tape output gating, two NANDs and an inverter
// =========================================================================

`timescale 1ns/10ps
`default_nettype none

module atom_cassette
#(
   parameter int CAS_HALF_PERIOD = atom_pkg::CAS_HALF_PERIOD
)
(
   input  logic       clk25,
   input  logic       reset,
   input  logic       access_en,
   input  logic [3:0] port_c,
   output logic       cas_tone,
   output logic       cas_out,
   output logic       sound
);

   localparam int DW = $clog2(CAS_HALF_PERIOD);

   logic [DW-1:0] cas_div;

   // Toggle once per half period of access enables
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         cas_div  <= '0;
         cas_tone <= 1'b0;
      end
      else if (access_en)
      begin
         if (cas_div == DW'(CAS_HALF_PERIOD - 1))
         begin
            cas_div  <= '0;
            cas_tone <= !cas_tone;
         end
         else
            cas_div <= cas_div + 1'b1;
      end
   end

   // pc0 low holds the line high, pc1 gates the tone
   assign cas_out = !(!(!cas_tone && port_c[1]) && port_c[0]);
   assign sound   = port_c[2];

endmodule

`default_nettype wire

// ==== design/atom_clken.sv ====
// =========================================================================
// Access enable generator
// Free-running frame counter over CLKDIV_PERIOD cycles of clk25
// Enable pattern chosen by the turbo setting
// =========================================================================

`timescale 1ns/10ps
`default_nettype none

module atom_clken
#(
   parameter int CLKDIV_PERIOD = atom_pkg::CLKDIV_PERIOD
)
(
   input  logic             clk25,
   input  logic             reset,
   input  atom_pkg::turbo_t turbo,
   output logic             access_en
);

   localparam int CW = $clog2(CLKDIV_PERIOD);
   // Enables only fall in the first 16 steps of the frame
   localparam int FAST_WINDOW = 16;

   logic [CW-1:0] cnt;
   logic          in_window;
   logic          en_next;

   // Frame counter, wraps at the period
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         cnt <= '0;
      else if (cnt == CW'(CLKDIV_PERIOD - 1))
         cnt <= '0;
      else
         cnt <= cnt + 1'b1;
   end

   assign in_window = (int'(cnt) < FAST_WINDOW);

   // Pattern per speed
   always_comb
   begin
      case (turbo)
         2'd0:    en_next = (cnt == '0);
         2'd1:    en_next = in_window && (cnt[2:0] == 3'd0);
         2'd2:    en_next = in_window && (cnt[1:0] == 2'd0);
         default: en_next = in_window && !cnt[0];
      endcase
   end

   // One cycle behind the counter
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         access_en <= 1'b0;
      else
         access_en <= en_next;
   end

endmodule

`default_nettype wire

// ==== design/atom_memmap.sv ====
// =========================================================================
// Address decoder and bus handshake
// Single-cycle ack, paged ROM latch at BFFF
// A000 window mapping into the 18-bit SRAM space
// ROM write masking and read-data multiplexer
// =========================================================================

`timescale 1ns/10ps
`default_nettype none

module atom_memmap
(
   input  logic                clk25,
   input  logic                reset,
   input  logic                access_en,
   input  logic                wb_cyc,
   input  logic                wb_stb,
   input  logic                wb_we,
   input  atom_pkg::addr_t     wb_adr,
   input  atom_pkg::data_t     wb_dat_w,
   input  atom_pkg::data_t     pia_dout,
   input  atom_pkg::data_t     ram_din,
   output logic                wb_ack,
   output atom_pkg::data_t     wb_dat_r,
   output logic                pia_wr,
   output atom_pkg::ram_addr_t ram_adr,
   output atom_pkg::data_t     ram_dout,
   output logic                ram_we_n,
   output logic                ram_oe_n
);

   import atom_pkg::*;

   data_t    rom_latch;
   page_t    page;
   dev_sel_t dev_sel;
   logic     a000_cs;
   logic     wr_cycle;

   assign page    = rom_latch[2:0];
   assign a000_cs = (wb_adr[15:12] == A000_BASE[15:12]);

   // =========================================================================
   // Decode
   // =========================================================================

   always_comb
   begin
      // C000-FFFF always ROM, A000 window unless opened
      if (wb_adr[15:14] == 2'b11)
         dev_sel = sel_rom;
      else if (a000_cs && (page != ROM_PAGE_OPEN))
         dev_sel = sel_rom;
      else if (wb_adr[15:4] == PIA_BASE[15:4])
         dev_sel = sel_pia;
      else if (wb_adr == LATCH_ADDR)
         dev_sel = sel_latch;
      else
         dev_sel = sel_ram;
   end

   // =========================================================================
   // Handshake and strobes
   // =========================================================================

   // Ack lands on the first enable of the request
   assign wb_ack   = wb_cyc && wb_stb && access_en;
   assign wr_cycle = wb_ack && wb_we;

   assign pia_wr   = wr_cycle && (dev_sel == sel_pia);
   // ROM, PIA and latch never reach the SRAM write strobe
   assign ram_we_n = !(wr_cycle && (dev_sel == sel_ram));
   assign ram_oe_n = !(wb_cyc && wb_stb && !wb_we);
   assign ram_dout = wb_dat_w;

   // Paged window goes to 010 + page, everything else stays low
   assign ram_adr = a000_cs ? {3'b010, page, wb_adr[11:0]} : {2'b00, wb_adr};

   // ROM page latch
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         rom_latch <= '0;
      else if (wr_cycle && (dev_sel == sel_latch))
         rom_latch <= wb_dat_w;
   end

   // Read data, ROM images live in SRAM as well
   always_comb
   begin
      case (dev_sel)
         sel_pia:   wb_dat_r = pia_dout;
         sel_latch: wb_dat_r = rom_latch;
         default:   wb_dat_r = ram_din;
      endcase
   end

endmodule

`default_nettype wire

// ==== design/atom_pia.sv ====
// =========================================================================
// 8255 PIA model, fixed port directions
// Port A output, port B input, port C split nibbles
// Bit set/reset on the control offset
// =========================================================================

`timescale 1ns/10ps
`default_nettype none

module atom_pia
(
   input  logic            clk25,
   input  logic            reset,
   input  logic            pia_wr,
   input  atom_pkg::addr_t wb_adr,
   input  atom_pkg::data_t wb_dat_w,
   input  atom_pkg::data_t key_cols,
   input  logic            rept_n,
   input  logic            fs_n,
   input  logic            cas_in,
   input  logic            cas_tone,
   output atom_pkg::data_t pia_dout,
   output logic [3:0]      key_row,
   output logic [3:0]      port_c
);

   import atom_pkg::*;

   data_t       pa_r;
   logic [3:0]  pc_r;
   logic [1:0]  offset;
   data_t       pc_in;

   assign offset = wb_adr[1:0];

   // =========================================================================
   // Register writes
   // =========================================================================

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         pa_r <= '0;
         pc_r <= '0;
      end
      else if (pia_wr)
      begin
         case (offset)
            2'd0: pa_r <= wb_dat_w;
            2'd2: pc_r <= wb_dat_w[3:0];
            // Control word, bit 7 clear means bit set/reset
            2'd3:
            begin
               if (!wb_dat_w[7])
                  pc_r[wb_dat_w[2:1]] <= wb_dat_w[0];
            end
            default: ;
         endcase
      end
   end

   // =========================================================================
   // Read side
   // =========================================================================

   // Upper port C nibble is all inputs
   assign pc_in = {fs_n, rept_n, cas_in, cas_tone, pc_r};

   always_comb
   begin
      case (offset)
         2'd0:    pia_dout = pa_r;
         2'd1:    pia_dout = key_cols;
         2'd2:    pia_dout = pc_in;
         default: pia_dout = '0;
      endcase
   end

   // Keyboard row select
   assign key_row = pa_r[3:0];
   assign port_c  = pc_r;

endmodule

`default_nettype wire

// ==== design/atom_pkg.sv ====
// =========================================================================
// Shared definitions for the system controller
// Bus, SRAM and page widths, turbo select type
// Memory map constants and decoded target enum
// Default divider periods for the top level
// =========================================================================

`default_nettype none

package atom_pkg;

   // =========================================================================
   // Widths
   // =========================================================================

   // CPU address and data byte
   typedef logic [15:0] addr_t;
   typedef logic [7:0]  data_t;

   // External SRAM, 256K x 8
   typedef logic [17:0] ram_addr_t;

   // ROM page from latch bits 2:0
   typedef logic [2:0]  page_t;

   // 0..3 select 1, 2, 4, 8 MHz
   typedef logic [1:0]  turbo_t;

   // Decoded target of an access
   typedef enum logic [1:0] {
      sel_ram,
      sel_rom,
      sel_pia,
      sel_latch
   } dev_sel_t;

   // =========================================================================
   // Timing defaults
   // =========================================================================

   // clk25 cycles per 1 us frame
   localparam int CLKDIV_PERIOD = 25;
   // Access enables per tone half period, 16 * 13
   localparam int CAS_HALF_PERIOD = 208;

   // =========================================================================
   // Memory map
   // =========================================================================

   // 8255 PIA, B000-B00F
   localparam addr_t PIA_BASE = 16'hb000;
   // Paged ROM latch
   localparam addr_t LATCH_ADDR = 16'hbfff;
   // Paged window, A000-AFFF
   localparam addr_t A000_BASE = 16'ha000;
   // This page turns the window into writable RAM
   localparam page_t ROM_PAGE_OPEN = 3'd7;

endpackage

`default_nettype wire

// ==== design/atom_sysctl.sv ====
// =========================================================================
// System controller top level
// Wishbone classic slave port, external SRAM pins
// Clock enable, memory map, PIA and cassette blocks
// =========================================================================

`timescale 1ns/10ps
`default_nettype none

module atom_sysctl
#(
   parameter int CLKDIV_PERIOD   = atom_pkg::CLKDIV_PERIOD,
   parameter int CAS_HALF_PERIOD = atom_pkg::CAS_HALF_PERIOD
)
(
   input  logic                clk25,
   input  logic                reset,
   // Wishbone classic
   input  logic                wb_cyc,
   input  logic                wb_stb,
   input  logic                wb_we,
   input  atom_pkg::addr_t     wb_adr,
   input  atom_pkg::data_t     wb_dat_w,
   output logic                wb_ack,
   output atom_pkg::data_t     wb_dat_r,
   // Speed select and keyboard
   input  atom_pkg::turbo_t    turbo,
   input  atom_pkg::data_t     key_cols,
   input  logic                rept_n,
   input  logic                fs_n,
   input  logic                cas_in,
   // External SRAM
   input  atom_pkg::data_t     ram_din,
   output atom_pkg::ram_addr_t ram_adr,
   output atom_pkg::data_t     ram_dout,
   output logic                ram_we_n,
   output logic                ram_oe_n,
   // Keyboard row, tape and speaker
   output logic [3:0]          key_row,
   output logic                cas_out,
   output logic                sound
);

   import atom_pkg::*;

   logic       access_en;
   logic       pia_wr;
   data_t      pia_dout;
   logic [3:0] port_c;
   logic       cas_tone;

   // =========================================================================
   // Clock enable
   // =========================================================================

   atom_clken #(
      .CLKDIV_PERIOD (CLKDIV_PERIOD)
   ) u_clken (
      .clk25     (clk25),
      .reset     (reset),
      .turbo     (turbo),
      .access_en (access_en)
   );

   // =========================================================================
   // Decode, latch and SRAM side
   // =========================================================================

   atom_memmap u_memmap (
      .clk25     (clk25),
      .reset     (reset),
      .access_en (access_en),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_dat_w  (wb_dat_w),
      .pia_dout  (pia_dout),
      .ram_din   (ram_din),
      .wb_ack    (wb_ack),
      .wb_dat_r  (wb_dat_r),
      .pia_wr    (pia_wr),
      .ram_adr   (ram_adr),
      .ram_dout  (ram_dout),
      .ram_we_n  (ram_we_n),
      .ram_oe_n  (ram_oe_n)
   );

   // PIA at B000
   atom_pia u_pia (
      .clk25    (clk25),
      .reset    (reset),
      .pia_wr   (pia_wr),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .key_cols (key_cols),
      .rept_n   (rept_n),
      .fs_n     (fs_n),
      .cas_in   (cas_in),
      .cas_tone (cas_tone),
      .pia_dout (pia_dout),
      .key_row  (key_row),
      .port_c   (port_c)
   );

   // Tone runs off the same access rate
   atom_cassette #(
      .CAS_HALF_PERIOD (CAS_HALF_PERIOD)
   ) u_cassette (
      .clk25     (clk25),
      .reset     (reset),
      .access_en (access_en),
      .port_c    (port_c),
      .cas_tone  (cas_tone),
      .cas_out   (cas_out),
      .sound     (sound)
   );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run tb_atom with Verilator, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM_BIN=tb_atom_sim

verilator --binary --timing --assert --timescale 1ns/10ps \
   --top-module tb_atom --Mdir "$BUILD_DIR" -o "$SIM_BIN" -f tb.f
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q 'All tests passed!' "$LOG"; then
   echo "Result: PASS"
   exit 0
else
   echo "Result: FAIL"
   exit 1
fi

// ==== tb.f ====
design/atom_pkg.sv
design/atom_clken.sv
design/atom_memmap.sv
design/atom_pia.sv
design/atom_cassette.sv
design/atom_sysctl.sv
testbench/atom_asserts.sv
testbench/tb_atom.sv

// ==== testbench/atom_asserts.sv ====
// ==========================================================================
// Concurrent checks on the memory map block
// Single-cycle ack, SRAM write strobe never on ROM
// SRAM write and output enables never together
// ==========================================================================

`timescale 1ns/10ps
`default_nettype none

module atom_asserts
(
   input logic               clk25,
   input logic               reset,
   input logic               wb_ack,
   input logic               ram_we_n,
   input logic               ram_oe_n,
   input atom_pkg::dev_sel_t dev_sel
);

   import atom_pkg::*;

   // Master drops the strobe after ack, so ack never repeats
   ack_one_cycle: assert property (@(posedge clk25) disable iff (reset)
      wb_ack |=> !wb_ack)
      else $error("wb_ack held high for more than one cycle");

   // ROM writes are masked
   no_rom_write: assert property (@(posedge clk25) disable iff (reset)
      !ram_we_n |-> (dev_sel != sel_rom))
      else $error("ram_we_n low on a ROM target");

   strobes_exclusive: assert property (@(posedge clk25) disable iff (reset)
      !(!ram_we_n && !ram_oe_n))
      else $error("ram_we_n and ram_oe_n low together");

endmodule

bind atom_memmap atom_asserts u_asserts (
   .clk25    (clk25),
   .reset    (reset),
   .wb_ack   (wb_ack),
   .ram_we_n (ram_we_n),
   .ram_oe_n (ram_oe_n),
   .dev_sel  (dev_sel)
);

`default_nettype wire

// ==== testbench/atom_patterns.txt ====
# Columns, hex: op turbo addr wdata expect mask sram_adr
# wr checks {sound, cas_out, key_row} after the write, rd checks wb_dat_r and ram_adr
# in drives key_cols from wdata and {fs_n, rept_n, cas_in} from addr[2:0]
# cas expects the clk25 cycle count between cas_out edges
# SRAM below 8000
rd 0 1234 00 30 ff 01234
wr 1 0400 a5 00 00 0
rd 1 0400 00 a5 ff 00400
wr 2 7ffe 3c 00 00 0
rd 2 7ffe 00 3c ff 07ffe
rd 3 7fff 00 e0 ff 07fff
# ROM area ignores writes
wr 0 c123 77 00 00 0
rd 0 c123 00 13 ff 0c123
wr 3 fff0 99 00 00 0
rd 3 fff0 00 cf ff 0fff0
# Page latch and A000 window
rd 0 bfff 00 00 ff 0bfff
rd 1 a010 00 50 ff 10010
wr 2 bfff 05 00 00 0
rd 2 bfff 00 05 ff 0bfff
wr 1 a020 11 00 00 0
rd 1 a020 00 74 ff 15020
wr 3 bfff 07 00 00 0
rd 3 bfff 00 07 ff 0bfff
wr 3 a020 66 00 00 0
rd 0 a020 00 66 ff 17020
rd 0 afff 00 a0 ff 17fff
# PIA ports and port C bit set/reset
in 0 0005 5c 00 00 0
wr 0 b000 a9 19 3f 0
rd 0 b000 00 a9 ff 0b000
rd 1 b001 00 5c ff 0b001
wr 1 b002 0a 19 3f 0
rd 1 b002 00 aa ef 0b002
wr 2 b003 05 39 3f 0
wr 2 b003 01 29 2f 0
wr 2 b003 02 29 3f 0
rd 2 b002 00 ad ef 0b002
wr 3 b003 8f 29 3f 0
rd 3 b002 00 ad ef 0b002
rd 3 b003 00 00 ff 0b003
wr 0 b003 04 09 3f 0
wr 0 b003 03 09 2f 0
in 0 0002 c3 00 00 0
rd 1 b001 00 c3 ff 0b001
rd 1 b002 00 4b ef 0b002
# Tone half period with pc0 and pc1 set
cas 0 0000 00 1450 00 0
cas 3 0000 00 028a 00 0
rd 2 0400 00 a5 ff 00400

// ==== testbench/tb_atom.sv ====
// ==========================================================================
// Testbench for the system controller
// Clock and reset, byte-wide SRAM model with address-derived preload
// Pattern replay from the stimulus file, Wishbone master task
// Compare tasks for data, SRAM address, single pins and tone period
// ==========================================================================

`timescale 1ns/10ps
`default_nettype none

module tb_atom;

   import atom_pkg::*;

   localparam int ACK_TIMEOUT = 100;
   // Slowest half period is 5200 cycles, allow a partial one first
   localparam int CAS_TIMEOUT = 16000;
   localparam int SRAM_WORDS  = 1 << 18;

   // Operation words from the stimulus file
   localparam logic [31:0] OP_WR  = 32'("wr");
   localparam logic [31:0] OP_RD  = 32'("rd");
   localparam logic [31:0] OP_IN  = 32'("in");
   localparam logic [31:0] OP_CAS = 32'("cas");

   logic       clk25;
   logic       reset;
   logic       wb_cyc;
   logic       wb_stb;
   logic       wb_we;
   addr_t      wb_adr;
   data_t      wb_dat_w;
   logic       wb_ack;
   data_t      wb_dat_r;
   turbo_t     turbo;
   data_t      key_cols;
   logic       rept_n;
   logic       fs_n;
   logic       cas_in;
   data_t      ram_din;
   ram_addr_t  ram_adr;
   data_t      ram_dout;
   logic       ram_we_n;
   logic       ram_oe_n;
   logic [3:0] key_row;
   logic       cas_out;
   logic       sound;

   data_t sram [SRAM_WORDS];
   int    line_no;

   atom_sysctl #(
      .CLKDIV_PERIOD   (CLKDIV_PERIOD),
      .CAS_HALF_PERIOD (CAS_HALF_PERIOD)
   ) dut (
      .clk25    (clk25),
      .reset    (reset),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_ack   (wb_ack),
      .wb_dat_r (wb_dat_r),
      .turbo    (turbo),
      .key_cols (key_cols),
      .rept_n   (rept_n),
      .fs_n     (fs_n),
      .cas_in   (cas_in),
      .ram_din  (ram_din),
      .ram_adr  (ram_adr),
      .ram_dout (ram_dout),
      .ram_we_n (ram_we_n),
      .ram_oe_n (ram_oe_n),
      .key_row  (key_row),
      .cas_out  (cas_out),
      .sound    (sound)
   );

   // 4 ns period
   initial
   begin
      clk25 = 1'b0;
      forever #2 clk25 = ~clk25;
   end

   // ==========================================================================
   // SRAM model
   // ==========================================================================

   // Preload, low address byte XOR address bits 17:10
   initial
   begin : sram_fill
      ram_addr_t fa;
      for (int i = 0; i < SRAM_WORDS; i++)
      begin
         fa = ram_addr_t'(i);
         sram[i] = fa[7:0] ^ fa[17:10];
      end
   end

   // Write strobe sampled at the edge that ends the ack cycle
   always @(posedge clk25)
   begin
      if (!ram_we_n)
         sram[ram_adr] = ram_dout;
   end

   assign ram_din = sram[ram_adr];

   // ==========================================================================
   // Failure handling and compare tasks
   // ==========================================================================

   task automatic stop_on_failure(input string reason);
      if (reason.len() > 0)
         $display("%s", reason);
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic check_data(input string name, input data_t got, input data_t expected);
      if (got !== expected)
      begin
         $display("Mismatch %s: got 0x%h, expected 0x%h (pattern line %0d)",
                  name, got, expected, line_no);
         stop_on_failure("");
      end
   endtask

   task automatic check_ram_addr(input string name, input ram_addr_t got,
                                 input ram_addr_t expected);
      if (got !== expected)
      begin
         $display("Mismatch %s: got 0x%h, expected 0x%h (pattern line %0d)",
                  name, got, expected, line_no);
         stop_on_failure("");
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic expected);
      if (got !== expected)
      begin
         $display("Mismatch %s: got 0x%h, expected 0x%h (pattern line %0d)",
                  name, got, expected, line_no);
         stop_on_failure("");
      end
   endtask

   task automatic confirm_period(input string name, input int got, input int expected);
      if (got != expected)
      begin
         $display("Mismatch %s: got 0x%h, expected 0x%h (pattern line %0d)",
                  name, got, expected, line_no);
         stop_on_failure("");
      end
   endtask

   // ==========================================================================
   // Bus master and measurements
   // ==========================================================================

   // Called just after a rising edge, returns on the edge ending the ack
   task automatic bus_access(input logic we, input addr_t adr, input data_t wdat,
                             output data_t rdat, output ram_addr_t radr);
      int waited;
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr;
      wb_dat_w <= wdat;
      waited = 0;
      do
      begin
         @(negedge clk25);
         waited++;
         if (waited > ACK_TIMEOUT)
            stop_on_failure($sformatf("No wb_ack for address %h within %0d cycles",
                                      adr, ACK_TIMEOUT));
      end
      while (wb_ack !== 1'b1);
      // Read data and address are valid while ack is high
      rdat = wb_dat_r;
      radr = ram_adr;
      // Output enable low on reads only
      check_bit("ram_oe_n", ram_oe_n, we);
      @(posedge clk25);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   // Pin byte is {sound, cas_out, key_row}, one mask bit per pin
   task automatic sample_pins(input data_t expected, input data_t mask);
      @(negedge clk25);
      if (mask[3:0] != 4'h0)
         check_data("key_row", {4'h0, key_row & mask[3:0]},
                    {4'h0, expected[3:0] & mask[3:0]});
      if (mask[4])
         check_bit("cas_out", cas_out, expected[4]);
      if (mask[5])
         check_bit("sound", sound, expected[5]);
   endtask

   // First edge may straddle a turbo change, the second interval is clean
   task automatic measure_cas_period(input int expected);
      logic last;
      int   cycles;
      @(negedge clk25);
      last   = cas_out;
      cycles = 0;
      do
      begin
         @(negedge clk25);
         cycles++;
         if (cycles > CAS_TIMEOUT)
            stop_on_failure("cas_out did not toggle before the timeout");
      end
      while (cas_out === last);
      last   = cas_out;
      cycles = 0;
      do
      begin
         @(negedge clk25);
         cycles++;
         if (cycles > CAS_TIMEOUT)
            stop_on_failure("cas_out stopped toggling before the timeout");
      end
      while (cas_out === last);
      confirm_period("cas_out half period", cycles, expected);
   endtask

   // ==========================================================================
   // Pattern replay
   // ==========================================================================

   initial
   begin : main_seq
      int          fd;
      int          code;
      int          patterns;
      string       line;
      logic [31:0] op;
      logic [31:0] f_turbo;
      logic [31:0] f_addr;
      logic [31:0] f_wdata;
      logic [31:0] f_exp;
      logic [31:0] f_mask;
      logic [31:0] f_sram;
      data_t       rdat;
      ram_addr_t   radr;

      reset    = 1'b1;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      turbo    = '0;
      key_cols = '0;
      rept_n   = 1'b1;
      fs_n     = 1'b1;
      cas_in   = 1'b0;
      line_no  = 0;
      patterns = 0;

      repeat (5) @(posedge clk25);
      reset <= 1'b0;

      // Idle state straight out of reset
      @(negedge clk25);
      check_bit("wb_ack", wb_ack, 1'b0);
      check_bit("ram_we_n", ram_we_n, 1'b1);
      check_bit("ram_oe_n", ram_oe_n, 1'b1);
      check_bit("cas_out", cas_out, 1'b1);

      fd = $fopen("testbench/atom_patterns.txt", "r");
      if (fd == 0)
         stop_on_failure("Cannot open the pattern file testbench/atom_patterns.txt");

      while (!$feof(fd))
      begin
         line = "";
         code = $fgets(line, fd);
         line_no++;
         // Skip blank and comment lines
         if (code > 0 && line.len() > 1 && line[0] != "#")
         begin
            op   = '0;
            code = $sscanf(line, "%s %h %h %h %h %h %h",
                           op, f_turbo, f_addr, f_wdata, f_exp, f_mask, f_sram);
            if (code != 7)
               stop_on_failure($sformatf("Pattern line %0d has a bad format", line_no));
            @(posedge clk25);
            turbo <= f_turbo[1:0];
            if (op == OP_WR)
            begin
               bus_access(1'b1, f_addr[15:0], f_wdata[7:0], rdat, radr);
               sample_pins(f_exp[7:0], f_mask[7:0]);
            end
            else if (op == OP_RD)
            begin
               bus_access(1'b0, f_addr[15:0], 8'h00, rdat, radr);
               check_data("wb_dat_r", rdat & f_mask[7:0], f_exp[7:0] & f_mask[7:0]);
               check_ram_addr("ram_adr", radr, f_sram[17:0]);
            end
            else if (op == OP_IN)
            begin
               key_cols <= f_wdata[7:0];
               {fs_n, rept_n, cas_in} <= f_addr[2:0];
            end
            else if (op == OP_CAS)
               measure_cas_period(int'(f_exp));
            else
               stop_on_failure($sformatf("Unknown operation on pattern line %0d", line_no));
            patterns++;
         end
      end
      $fclose(fd);

      if (patterns == 0)
         stop_on_failure("The pattern file holds no operations");

      @(posedge clk25);
      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire
